//--- vga_defs.svh
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

////////////////////////////////////////
// horizontal timing, in pixels
////////////////////////////////////////
`define VGA_HD 640
`define VGA_HF 16
`define VGA_HS 96
`define VGA_HB 48
`define VGA_HT 800

////////////////////////////////////////
// vertical timing, in lines
////////////////////////////////////////
`define VGA_VD 480
`define VGA_VF 10
`define VGA_VS 2
`define VGA_VB 33
`define VGA_VT 525

// source image held in the rom
`define IMG_W 320
`define IMG_H 240
`define IMG_WORDS 76800
`define ADDR_W 17

`endif

//--- vga_pkg.sv
package vga_pkg;

    // raster position straight from the counters
    typedef struct packed {
        logic [9:0] h;
        logic [9:0] v;
        logic       active;
    } scan_pos_t;

    // user controls as they arrive at the top
    typedef struct packed {
        logic en;
        logic dir;
        logic vmir;
        logic hmir;
        logic enlarge;
    } view_in_t;

    // view held constant for one whole frame
    typedef struct packed {
        logic [8:0] run_x;
        logic [7:0] run_y;
        logic       hmir;
        logic       vmir;
        logic [1:0] zoom;
    } view_state_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // active low syncs, active high display enable
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;

endpackage

//--- vga_timing.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module vga_timing (
    input  logic               clk,
    input  logic               rst,
    output vga_pkg::scan_pos_t pos_o,
    output vga_pkg::sync_t     sync_o,
    output logic               frame_start_o
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_last;
    logic       v_last;
    logic       active;

    assign h_last = (h_cnt == `VGA_HT - 1);
    assign v_last = (v_cnt == `VGA_VT - 1);

    ////////////////////////////////////////
    // pixel and line counters
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // line count moves once per horizontal wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v_cnt <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end
    end

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    assign active = (h_cnt < `VGA_HD) && (v_cnt < `VGA_VD);

    always_comb begin
        pos_o.h      = h_cnt;
        pos_o.v      = v_cnt;
        pos_o.active = active;

        sync_o.hsync = !((h_cnt >= `VGA_HD + `VGA_HF) &&
                         (h_cnt <  `VGA_HD + `VGA_HF + `VGA_HS));
        sync_o.vsync = !((v_cnt >= `VGA_VD + `VGA_VF) &&
                         (v_cnt <  `VGA_VD + `VGA_VF + `VGA_VS));
        sync_o.de    = active;
    end

    // last cycle of the last line
    assign frame_start_o = h_last && v_last;

endmodule

//--- view_ctrl.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module view_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  vga_pkg::view_in_t    view_i,
    input  logic                 frame_start_i,
    output vga_pkg::view_state_t view_o
);

    import vga_pkg::*;

    view_state_t view_q;
    view_state_t view_nxt;

    ////////////////////////////////////////
    // next frame view
    ////////////////////////////////////////
    always_comb begin
        view_nxt = view_q;

        if (!view_i.en) begin
            view_nxt.run_x = '0;
            view_nxt.run_y = '0;
        end else if (view_i.dir) begin
            // right and up
            view_nxt.run_x = (view_q.run_x == 9'(`IMG_W - 1)) ? 9'd0
                                                              : view_q.run_x + 9'd1;
            view_nxt.run_y = (view_q.run_y == 8'd0) ? 8'(`IMG_H - 1)
                                                    : view_q.run_y - 8'd1;
        end else begin
            // left and down
            view_nxt.run_x = (view_q.run_x == 9'd0) ? 9'(`IMG_W - 1)
                                                    : view_q.run_x - 9'd1;
            view_nxt.run_y = (view_q.run_y == 8'(`IMG_H - 1)) ? 8'd0
                                                              : view_q.run_y + 8'd1;
        end

        view_nxt.hmir = view_i.hmir;
        view_nxt.vmir = view_i.vmir;
        view_nxt.zoom = view_i.enlarge ? 2'd2 : 2'd1;
    end

    // only changes between frames, so no frame ever tears
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            view_q.run_x <= '0;
            view_q.run_y <= '0;
            view_q.hmir  <= 1'b0;
            view_q.vmir  <= 1'b0;
            view_q.zoom  <= 2'd1;
        end else if (frame_start_i) begin
            view_q <= view_nxt;
        end
    end

    assign view_o = view_q;

endmodule

//--- addr_gen.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module addr_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  vga_pkg::scan_pos_t   pos_i,
    input  vga_pkg::view_state_t view_i,
    output logic [`ADDR_W-1:0]   addr_o,
    output logic                 active_o
);

    logic        [9:0]  h_eff;
    logic        [9:0]  v_eff;
    logic signed [11:0] dx;
    logic signed [11:0] dy;
    logic signed [11:0] sx;
    logic signed [11:0] sy;
    logic signed [11:0] x_wrap;
    logic signed [11:0] y_wrap;
    logic        [8:0]  x_src;
    logic        [7:0]  y_src;

    // blanking positions fold onto the origin so the address stays in range
    assign h_eff = pos_i.active ? pos_i.h : 10'd0;
    assign v_eff = pos_i.active ? pos_i.v : 10'd0;

    // distance from screen centre, scaled down by the zoom shift
    assign dx = $signed({2'b00, h_eff}) - 12'sd320;
    assign dy = $signed({2'b00, v_eff}) - 12'sd240;

    assign sx = 12'sd160 + (dx >>> view_i.zoom) + $signed({3'b000, view_i.run_x});
    assign sy = 12'sd120 + (dy >>> view_i.zoom) + $signed({4'b0000, view_i.run_y});

    // one subtract is enough, sx stays below 2*IMG_W in the active area
    assign x_wrap = (sx >= 12'(`IMG_W)) ? sx - 12'(`IMG_W) : sx;
    assign y_wrap = (sy >= 12'(`IMG_H)) ? sy - 12'(`IMG_H) : sy;

    assign x_src = view_i.hmir ? 9'(`IMG_W - 1) - x_wrap[8:0] : x_wrap[8:0];
    assign y_src = view_i.vmir ? 8'(`IMG_H - 1) - y_wrap[7:0] : y_wrap[7:0];

    always_ff @(posedge clk) begin
        addr_o <= `ADDR_W'(y_src) * `ADDR_W'(`IMG_W) + `ADDR_W'(x_src);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_o <= 1'b0;
        end else begin
            active_o <= pos_i.active;
        end
    end

endmodule

//--- image_rom.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module image_rom (
    input  logic               clk,
    input  logic [`ADDR_W-1:0] addr_i,
    output logic [11:0]        word_o
);

    logic [11:0] mem [0:`IMG_WORDS-1];

    ////////////////////////////////////////
    // contents
    ////////////////////////////////////////
    // each word is its address folded onto itself
    initial begin
        for (int i = 0; i < `IMG_WORDS; i++) begin
            mem[i] = 12'(i ^ (i >> 5));
        end
    end

    always_ff @(posedge clk) begin
        word_o <= mem[addr_i];
    end

endmodule

//--- pixel_out.sv
`timescale 1ns/1ns

module pixel_out (
    input  logic           clk,
    input  logic           rst,
    input  vga_pkg::sync_t sync_i,
    input  logic           active_i,
    input  logic [11:0]    word_i,
    output vga_pkg::rgb_t  rgb_o,
    output logic           hsync_o,
    output logic           vsync_o,
    output logic           de_o
);

    import vga_pkg::*;

    sync_t sync_d1;
    sync_t sync_d2;
    logic  active_d1;

    // sync travels two stages, active one, to meet the rom word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_d1   <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
            sync_d2   <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
            active_d1 <= 1'b0;
        end else begin
            sync_d1   <= sync_i;
            sync_d2   <= sync_d1;
            active_d1 <= active_i;
        end
    end

    ////////////////////////////////////////
    // output registers
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_o   <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            de_o    <= 1'b0;
        end else begin
            rgb_o   <= active_d1 ? rgb_t'(word_i) : '0;
            hsync_o <= sync_d2.hsync;
            vsync_o <= sync_d2.vsync;
            de_o    <= sync_d2.de;
        end
    end

endmodule

//--- vga_top.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module vga_top (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::view_in_t view_i,
    output vga_pkg::rgb_t     rgb_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              de_o
);

    import vga_pkg::*;

    scan_pos_t          pos;
    sync_t              sync_raw;
    logic               frame_start;
    view_state_t        view;
    logic [`ADDR_W-1:0] rom_addr;
    logic               addr_active;
    logic [11:0]        rom_word;

    vga_timing u_timing (
        .clk           (clk),
        .rst           (rst),
        .pos_o         (pos),
        .sync_o        (sync_raw),
        .frame_start_o (frame_start)
    );

    view_ctrl u_view (
        .clk           (clk),
        .rst           (rst),
        .view_i        (view_i),
        .frame_start_i (frame_start),
        .view_o        (view)
    );

    // address stage then rom, two cycles of latency before pixel_out
    addr_gen u_addr (
        .clk      (clk),
        .rst      (rst),
        .pos_i    (pos),
        .view_i   (view),
        .addr_o   (rom_addr),
        .active_o (addr_active)
    );

    image_rom u_rom (
        .clk    (clk),
        .addr_i (rom_addr),
        .word_o (rom_word)
    );

    pixel_out u_out (
        .clk      (clk),
        .rst      (rst),
        .sync_i   (sync_raw),
        .active_i (addr_active),
        .word_i   (rom_word),
        .rgb_o    (rgb_o),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .de_o     (de_o)
    );

endmodule

//--- vga_asserts.sv
`timescale 1ns/1ns

module vga_asserts (
    input logic          clk,
    input logic          rst,
    input vga_pkg::rgb_t rgb_i,
    input logic          hsync_i,
    input logic          vsync_i,
    input logic          de_i
);

    // no picture while either sync pulse is running
    de_in_sync: assert property (@(posedge clk) disable iff (rst)
        de_i |-> (hsync_i && vsync_i))
        else $error("de_o high while a sync is low");

    blank_black: assert property (@(posedge clk) disable iff (rst)
        !de_i |-> (rgb_i == '0))
        else $error("rgb_o not zero during blanking");

    // vsync edges fall at the start of a line, outside hsync and picture
    vsync_edge: assert property (@(posedge clk) disable iff (rst)
        (vsync_i != $past(vsync_i)) |-> (hsync_i && !de_i))
        else $error("vsync_o changed away from a line start");

endmodule

bind vga_top vga_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .rgb_i   (rgb_o),
    .hsync_i (hsync_o),
    .vsync_i (vsync_o),
    .de_i    (de_o)
);

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 50 MHz pixel clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset spans three rising edges, released just after the third
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

//--- tb_checker.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module tb_checker (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::view_in_t view_i,
    input  vga_pkg::rgb_t     rgb_i,
    input  vga_pkg::sync_t    sync_i,
    output int                pix_checked_o,
    output int                pix_errs_o,
    output int                sync_errs_o
);

    import vga_pkg::*;

    sync_t prev;
    int    x;
    int    y;
    int    cyc;
    int    hfall_cyc;
    int    vfall_cyc;
    int    de_cyc;
    // view model for the frame on screen
    int    run_x;
    int    run_y;
    int    zoom;
    bit    hmir;
    bit    vmir;
    int    pix_checked = 0;
    int    pix_errs = 0;
    int    sync_errs = 0;

    assign pix_checked_o = pix_checked;
    assign pix_errs_o    = pix_errs;
    assign sync_errs_o   = sync_errs;

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            sync_errs++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    // scroll step plus latch of mirrors and zoom, once per frame
    task automatic update_view();
        if (!view_i.en) begin
            run_x = 0;
            run_y = 0;
        end else if (view_i.dir) begin
            run_x = (run_x + 1) % `IMG_W;
            run_y = (run_y + `IMG_H - 1) % `IMG_H;
        end else begin
            run_x = (run_x + `IMG_W - 1) % `IMG_W;
            run_y = (run_y + 1) % `IMG_H;
        end
        hmir = view_i.hmir;
        vmir = view_i.vmir;
        zoom = view_i.enlarge ? 2 : 1;
    endtask

    ////////////////////////////////////////
    // reference colour for screen pixel
    ////////////////////////////////////////
    function automatic logic [11:0] ref_color(input int px, input int py);
        int sx;
        int sy;
        int a;
        sx = 160 + ((px - 320) >>> zoom) + run_x;
        sy = 120 + ((py - 240) >>> zoom) + run_y;
        sx = ((sx % `IMG_W) + `IMG_W) % `IMG_W;
        sy = ((sy % `IMG_H) + `IMG_H) % `IMG_H;
        if (hmir) begin
            sx = `IMG_W - 1 - sx;
        end
        if (vmir) begin
            sy = `IMG_H - 1 - sy;
        end
        a = sy * `IMG_W + sx;
        return 12'(a ^ (a >> 5));
    endfunction

    always @(negedge clk) begin
        logic [11:0] exp_rgb;
        if (rst) begin
            check_value("de_o", sync_i.de, 0);
            check_value("hsync_o", sync_i.hsync, 1);
            check_value("vsync_o", sync_i.vsync, 1);
            check_value("rgb_o", rgb_i, 0);
            x = 0;
            y = 0;
            cyc = 0;
            hfall_cyc = -1;
            vfall_cyc = -1;
            de_cyc = 0;
            run_x = 0;
            run_y = 0;
            zoom = 1;
            hmir = 1'b0;
            vmir = 1'b0;
            prev = sync_i;
        end else begin
            cyc++;
            if (prev.hsync && !sync_i.hsync) begin
                if (hfall_cyc >= 0) begin
                    check_value("hsync_o period", cyc - hfall_cyc, `VGA_HT);
                end
                hfall_cyc = cyc;
            end
            if (!prev.hsync && sync_i.hsync && hfall_cyc >= 0) begin
                check_value("hsync_o low time", cyc - hfall_cyc, `VGA_HS);
            end
            if (prev.vsync && !sync_i.vsync) begin
                if (vfall_cyc >= 0) begin
                    check_value("vsync_o period", cyc - vfall_cyc, `VGA_HT * `VGA_VT);
                end
                check_value("de_o lines per frame", y, `VGA_VD);
                vfall_cyc = cyc;
                x = 0;
                y = 0;
            end
            if (!prev.vsync && sync_i.vsync && vfall_cyc >= 0) begin
                check_value("vsync_o low time", cyc - vfall_cyc, `VGA_VS * `VGA_HT);
            end
            if (!prev.de && sync_i.de) begin
                de_cyc = cyc;
                // first active pixel of the frame
                if (y == 0) begin
                    update_view();
                end
            end
            if (prev.de && !sync_i.de) begin
                check_value("de_o high time", cyc - de_cyc, `VGA_HD);
                x = 0;
                y++;
            end
            if (sync_i.de) begin
                exp_rgb = ref_color(x, y);
                pix_checked++;
                if (rgb_i !== exp_rgb) begin
                    pix_errs++;
                    if (pix_errs <= 10) begin
                        $display("ERROR rgb_o at x=%0d y=%0d: got %h expected %h",
                                 x, y, rgb_i, exp_rgb);
                    end
                end
                x++;
            end
            prev = sync_i;
        end
    end

endmodule

//--- tb_vga.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module tb_vga;

    import vga_pkg::*;

    localparam int FRAMES       = 8;
    localparam int FRAME_PIXELS = `VGA_HD * `VGA_VD;
    localparam int MAX_CYCLES   = 9 * `VGA_HT * `VGA_VT;

    logic     clk;
    logic     rst;
    view_in_t view_i;
    rgb_t     rgb_o;
    logic     hsync_o;
    logic     vsync_o;
    logic     de_o;
    sync_t    sync_mon;
    int       pix_checked;
    int       pix_errs;
    int       sync_errs;
    int       cycles;
    view_in_t cfg [FRAMES];

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    vga_top dut (
        .clk     (clk),
        .rst     (rst),
        .view_i  (view_i),
        .rgb_o   (rgb_o),
        .hsync_o (hsync_o),
        .vsync_o (vsync_o),
        .de_o    (de_o)
    );

    assign sync_mon.hsync = hsync_o;
    assign sync_mon.vsync = vsync_o;
    assign sync_mon.de    = de_o;

    tb_checker u_chk (
        .clk           (clk),
        .rst           (rst),
        .view_i        (view_i),
        .rgb_i         (rgb_o),
        .sync_i        (sync_mon),
        .pix_checked_o (pix_checked),
        .pix_errs_o    (pix_errs),
        .sync_errs_o   (sync_errs)
    );

    // new controls go in during vertical blanking, ahead of the next frame
    task automatic apply_view(input view_in_t v);
        @(negedge vsync_o);
        @(posedge clk);
        #2;
        view_i = v;
    endtask

    task automatic finish_run(input bit timed_out);
        bit short_run;
        short_run = (pix_checked != FRAMES * FRAME_PIXELS);
        if (short_run && !timed_out) begin
            $display("checked %0d active pixels where %0d were due",
                     pix_checked, FRAMES * FRAME_PIXELS);
        end
        $display("pixel errors %0d, sync and reset errors %0d, pixels checked %0d",
                 pix_errs, sync_errs, pix_checked);
        if (timed_out || short_run || pix_errs != 0 || sync_errs != 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // frame sequence
    ////////////////////////////////////////
    initial begin
        for (int i = 0; i < FRAMES; i++) begin
            cfg[i] = '0;
        end
        cfg[1].enlarge = 1'b1;
        cfg[2].hmir    = 1'b1;
        cfg[3].vmir    = 1'b1;
        cfg[4].hmir    = 1'b1;
        cfg[4].vmir    = 1'b1;
        cfg[5].en      = 1'b1;
        cfg[5].dir     = 1'b1;
        cfg[6].en      = 1'b1;
        view_i = cfg[0];
        @(negedge rst);
        for (int i = 1; i < FRAMES; i++) begin
            apply_view(cfg[i]);
        end
        // last frame is fully out once its vsync starts
        @(negedge vsync_o);
        repeat (4) @(posedge clk);
        finish_run(1'b0);
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, frame sequence did not complete", cycles);
        finish_run(1'b1);
    end

endmodule

//--- verilog.f
+incdir+.
vga_pkg.sv
vga_timing.sv
view_ctrl.sv
addr_gen.sv
image_rom.sv
pixel_out.sv
vga_top.sv
vga_asserts.sv
tb_clock_gen.sv
tb_checker.sv
tb_vga.sv

//--- Makefile
# Verilator build and run of the VGA testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_vga -f verilog.f
	out=$$(./obj_dir/Vtb_vga); \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
